// File: hw/ddr_dma_pkg.sv
package ddr_dma_pkg;

    // *************************************************************************
    // controller user port
    // *************************************************************************

    typedef struct packed {
        logic        en;         // one-cycle strobe.
        logic [2:0]  instr;
        logic [5:0]  bl;         // n moves n+1 words.
        logic [29:0] byte_addr;
    } mig_cmd_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  mask;       // 1 masks a byte.
        logic [31:0] data;
    } mig_wr_t;

    // fifo state from the controller.
    typedef struct packed {
        logic cmd_full;
        logic wr_full;
        logic rd_empty;
        logic rd_count_nz;
    } mig_stat_t;

    // *************************************************************************
    // dma configuration and address map
    // *************************************************************************

    typedef struct packed {
        logic [24:0] dram_word_addr;
        logic [9:0]  spad_addr;
        logic [5:0]  burst_len;
    } dma_cfg_t;

    localparam logic [2:0] CMD_WR = 3'b010;
    localparam logic [2:0] CMD_RD = 3'b011;

    localparam logic [3:0] SPAD_BASE = 4'h1;     // 0x1000 window.

    localparam logic [15:0] REG_DRAM_ADDR = 16'hc100;
    localparam logic [15:0] REG_SPAD_ADDR = 16'hc101;
    localparam logic [15:0] REG_BURST     = 16'hc102;
    localparam logic [15:0] REG_CTRL      = 16'hc103;

endpackage

// File: hw/spad_ram.sv
`timescale 1ns/1ns

module spad_ram #(
    parameter int SPAD_AW = 10
) (
    input  logic               clk,

    // bus side.
    input  logic [SPAD_AW-1:0] a_addr_i,
    input  logic               a_we_i,
    input  logic [31:0]        a_data_i,
    output logic [31:0]        a_data_o,

    // dma side.
    input  logic [SPAD_AW-1:0] b_addr_i,
    input  logic               b_we_i,
    input  logic [31:0]        b_data_i,
    output logic [31:0]        b_data_o
);

    localparam int DEPTH = 1 << SPAD_AW;

    logic [31:0] mem [DEPTH];

    logic [31:0] a_rdata_q;
    logic [31:0] b_rdata_q;

    // both ports write in one block so the later one is port b.
    always_ff @(posedge clk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_data_i;
        end
        if (b_we_i) begin
            mem[b_addr_i] <= b_data_i;    // b wins on collision.
        end
    end

    // registered reads, old data on read during write.
    always_ff @(posedge clk) begin
        a_rdata_q <= mem[a_addr_i];
        b_rdata_q <= mem[b_addr_i];
    end

    assign a_data_o = a_rdata_q;
    assign b_data_o = b_rdata_q;

    // *************************************************************************
    // checks
    // *************************************************************************

    // software must not write a word that the dma is filling.
    a_b_write_collision: assert property (
        @(posedge clk)
        !(a_we_i && b_we_i && (a_addr_i == b_addr_i))
    ) else $error("spad_ram: bus and dma write the same word");

endmodule

// File: hw/dma_regs.sv
`timescale 1ns/1ns

module dma_regs #(
    parameter int SPAD_AW = 10
) (
    input  logic                  clk,
    input  logic                  rst,

    // processor bus.
    input  logic [15:0]           addr_i,
    input  logic [31:0]           data_i,
    input  logic                  we_i,
    output logic [31:0]           data_o,

    // engine.
    input  logic                  idle_i,
    output ddr_dma_pkg::dma_cfg_t cfg_o,
    output logic                  start_o,
    output logic                  dir_o,

    // scratchpad port a.
    input  logic [31:0]           spad_rdata_i,
    output logic [SPAD_AW-1:0]    spad_addr_o,
    output logic                  spad_we_o,
    output logic [31:0]           spad_wdata_o
);

    ddr_dma_pkg::dma_cfg_t cfg_q;

    logic        spad_hit;
    logic        ready;
    logic        start_q;
    logic        dir_q;
    logic        spad_sel_q;
    logic [31:0] reg_rdata;
    logic [31:0] reg_rdata_q;

    assign spad_hit = (addr_i[15:12] == ddr_dma_pkg::SPAD_BASE);

    // engine still idle on the start cycle, so mask it.
    assign ready = idle_i && !start_q;

    assign spad_addr_o  = addr_i[SPAD_AW-1:0];
    assign spad_we_o    = we_i && spad_hit;
    assign spad_wdata_o = data_i;

    // *************************************************************************
    // config and control
    // *************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q      <= '0;
            start_q    <= 1'b0;
            dir_q      <= 1'b0;
            spad_sel_q <= 1'b0;
        end else begin
            start_q    <= 1'b0;
            spad_sel_q <= spad_hit;
            if (we_i) begin
                case (addr_i)
                    ddr_dma_pkg::REG_DRAM_ADDR: cfg_q.dram_word_addr <= data_i[26:2];
                    ddr_dma_pkg::REG_SPAD_ADDR: cfg_q.spad_addr <= data_i[9:0];
                    ddr_dma_pkg::REG_BURST:     cfg_q.burst_len <= data_i[5:0];
                    ddr_dma_pkg::REG_CTRL: begin
                        if (ready) begin        // ignored while busy.
                            start_q <= 1'b1;
                            dir_q   <= data_i[0];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // register readback.
    always_comb begin
        case (addr_i)
            ddr_dma_pkg::REG_DRAM_ADDR: reg_rdata = {5'b0, cfg_q.dram_word_addr, 2'b00};
            ddr_dma_pkg::REG_SPAD_ADDR: reg_rdata = {22'b0, cfg_q.spad_addr};
            ddr_dma_pkg::REG_BURST:     reg_rdata = {26'b0, cfg_q.burst_len};
            ddr_dma_pkg::REG_CTRL:      reg_rdata = {31'b0, ready};
            default:                    reg_rdata = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        reg_rdata_q <= reg_rdata;
    end

    // scratchpad data is already registered in the ram.
    assign data_o  = spad_sel_q ? spad_rdata_i : reg_rdata_q;

    assign cfg_o   = cfg_q;
    assign start_o = start_q;
    assign dir_o   = dir_q;

    // start only reaches an idle engine, which then leaves idle.
    start_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        start_o |-> idle_i ##1 !idle_i
    ) else $error("dma_regs: start pulse while engine busy");

endmodule

// File: hw/dma_engine.sv
`timescale 1ns/1ns

module dma_engine #(
    parameter int SPAD_AW = 10
) (
    input  logic                   clk,
    input  logic                   rst,

    // from the register block.
    input  ddr_dma_pkg::dma_cfg_t  cfg_i,
    input  logic                   start_i,
    input  logic                   dir_i,
    output logic                   idle_o,

    // controller port.
    input  ddr_dma_pkg::mig_stat_t mig_stat_i,
    input  logic [31:0]            rd_data_i,
    output ddr_dma_pkg::mig_cmd_t  mig_cmd_o,
    output ddr_dma_pkg::mig_wr_t   mig_wr_o,
    output logic                   rd_en_o,

    // scratchpad port b.
    input  logic [31:0]            spad_rdata_i,
    output logic [SPAD_AW-1:0]     spad_addr_o,
    output logic                   spad_we_o,
    output logic [31:0]            spad_wdata_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FILL,        // scratchpad to write fifo.
        ST_WR_CMD,
        ST_RD_CMD,
        ST_DRAIN        // read fifo to scratchpad.
    } state_t;

    state_t                state_q;
    ddr_dma_pkg::dma_cfg_t cfg_q;

    logic [SPAD_AW-1:0] ptr_q;          // next scratchpad word.
    logic [SPAD_AW-1:0] addr_q;         // word in the ram output.
    logic [6:0]         issue_left_q;
    logic [5:0]         words_left_q;
    logic               vld_q;          // ram output holds a word to push.

    logic stall;
    logic issue;
    logic push;
    logic cmd_fire;
    logic take;

    // *************************************************************************
    // handshakes
    // *************************************************************************

    assign stall    = vld_q && mig_stat_i.wr_full;
    assign issue    = (state_q == ST_FILL) && !stall && (issue_left_q != 7'd0);
    assign push     = vld_q && !mig_stat_i.wr_full;
    assign cmd_fire = ((state_q == ST_WR_CMD) || (state_q == ST_RD_CMD))
                      && !mig_stat_i.cmd_full;
    assign take     = (state_q == ST_DRAIN) && !mig_stat_i.rd_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= ST_IDLE;
            ptr_q        <= '0;
            issue_left_q <= 7'd0;
            words_left_q <= 6'd0;
            vld_q        <= 1'b0;
        end else begin
            if (issue) begin
                vld_q <= 1'b1;
            end else if (!stall) begin
                vld_q <= 1'b0;
            end

            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        ptr_q        <= SPAD_AW'(cfg_i.spad_addr);
                        issue_left_q <= {1'b0, cfg_i.burst_len} + 7'd1;
                        words_left_q <= cfg_i.burst_len;
                        state_q      <= dir_i ? ST_FILL : ST_RD_CMD;
                    end
                end
                ST_FILL: begin
                    if (issue) begin
                        ptr_q        <= ptr_q + 1'b1;
                        issue_left_q <= issue_left_q - 7'd1;
                    end
                    if (push) begin
                        if (words_left_q == 6'd0) begin
                            state_q <= ST_WR_CMD;
                        end else begin
                            words_left_q <= words_left_q - 6'd1;
                        end
                    end
                end
                ST_WR_CMD: begin
                    if (cmd_fire) state_q <= ST_IDLE;
                end
                ST_RD_CMD: begin
                    if (cmd_fire) state_q <= ST_DRAIN;
                end
                ST_DRAIN: begin
                    if (take) begin
                        ptr_q <= ptr_q + 1'b1;
                        if (words_left_q == 6'd0) begin
                            state_q <= ST_IDLE;
                        end else begin
                            words_left_q <= words_left_q - 6'd1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // transfer payload.
    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && start_i) cfg_q <= cfg_i;
        if (issue) addr_q <= ptr_q;
    end

    // *************************************************************************
    // outputs
    // *************************************************************************

    // a stalled push re-reads its word so the ram output stays valid.
    assign spad_addr_o  = stall ? addr_q : ptr_q;
    assign spad_we_o    = take;
    assign spad_wdata_o = rd_data_i;

    assign mig_cmd_o.en        = cmd_fire;
    assign mig_cmd_o.instr     = (state_q == ST_RD_CMD) ? ddr_dma_pkg::CMD_RD
                                                        : ddr_dma_pkg::CMD_WR;
    assign mig_cmd_o.bl        = cfg_q.burst_len;
    assign mig_cmd_o.byte_addr = {3'b000, cfg_q.dram_word_addr, 2'b00};

    assign mig_wr_o.en   = push;
    assign mig_wr_o.mask = 4'b0000;      // all bytes written.
    assign mig_wr_o.data = spad_rdata_i;

    assign rd_en_o = take;
    assign idle_o  = (state_q == ST_IDLE);

    // a stalled word stays on the write port until it is pushed.
    wr_word_held: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> $stable(mig_wr_o.data)
    ) else $error("dma_engine: write data changed during a stall");

    rd_only_when_data: assert property (
        @(posedge clk) disable iff (rst)
        rd_en_o |-> mig_stat_i.rd_count_nz
    ) else $error("dma_engine: read fifo popped while empty");

endmodule

// File: hw/ddr_dma_top.sv
`timescale 1ns/1ns

module ddr_dma_top #(
    parameter int SPAD_AW = 10
) (
    input  logic                   clk,
    input  logic                   rst,

    // processor bus.
    input  logic [15:0]            addr_i,
    input  logic [31:0]            data_i,
    input  logic                   we_i,
    output logic [31:0]            data_o,

    // ddr controller user port.
    output ddr_dma_pkg::mig_cmd_t  mig_cmd_o,
    output ddr_dma_pkg::mig_wr_t   mig_wr_o,
    output logic                   mig_rd_en_o,
    input  logic [31:0]            mig_rd_data_i,
    input  ddr_dma_pkg::mig_stat_t mig_stat_i
);

    ddr_dma_pkg::dma_cfg_t cfg;

    logic               start;
    logic               dir;
    logic               idle;

    // scratchpad ports.
    logic [SPAD_AW-1:0] a_addr;
    logic               a_we;
    logic [31:0]        a_wdata;
    logic [31:0]        a_rdata;
    logic [SPAD_AW-1:0] b_addr;
    logic               b_we;
    logic [31:0]        b_wdata;
    logic [31:0]        b_rdata;

    dma_regs #(
        .SPAD_AW (SPAD_AW)
    ) dma_regs_i (
        .clk          (clk),
        .rst          (rst),
        .addr_i       (addr_i),
        .data_i       (data_i),
        .we_i         (we_i),
        .data_o       (data_o),
        .idle_i       (idle),
        .cfg_o        (cfg),
        .start_o      (start),
        .dir_o        (dir),
        .spad_rdata_i (a_rdata),
        .spad_addr_o  (a_addr),
        .spad_we_o    (a_we),
        .spad_wdata_o (a_wdata)
    );

    spad_ram #(
        .SPAD_AW (SPAD_AW)
    ) spad_ram_i (
        .clk      (clk),
        .a_addr_i (a_addr),
        .a_we_i   (a_we),
        .a_data_i (a_wdata),
        .a_data_o (a_rdata),
        .b_addr_i (b_addr),
        .b_we_i   (b_we),
        .b_data_i (b_wdata),
        .b_data_o (b_rdata)
    );

    dma_engine #(
        .SPAD_AW (SPAD_AW)
    ) dma_engine_i (
        .clk          (clk),
        .rst          (rst),
        .cfg_i        (cfg),
        .start_i      (start),
        .dir_i        (dir),
        .idle_o       (idle),
        .mig_stat_i   (mig_stat_i),
        .rd_data_i    (mig_rd_data_i),
        .mig_cmd_o    (mig_cmd_o),
        .mig_wr_o     (mig_wr_o),
        .rd_en_o      (mig_rd_en_o),
        .spad_rdata_i (b_rdata),
        .spad_addr_o  (b_addr),
        .spad_we_o    (b_we),
        .spad_wdata_o (b_wdata)
    );

endmodule

// File: tests/mig_port_model.sv
`timescale 1ns/1ns

module mig_port_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bp_en_i,      // random back-pressure.
    input  ddr_dma_pkg::mig_cmd_t  cmd_i,
    input  ddr_dma_pkg::mig_wr_t   wr_i,
    input  logic                   rd_en_i,
    output logic [31:0]            rd_data_o,
    output ddr_dma_pkg::mig_stat_t stat_o
);

    logic [31:0] dram [256];        // filled by the testbench.
    logic [31:0] wr_fifo [$];
    logic [31:0] rd_pend [$];       // fetched, not yet visible.
    logic [31:0] rd_fifo [$];
    logic [7:0]  waddr;
    int          rd_wait = 0;
    int          seed = 79777;
    int          errors = 0;

    ddr_dma_pkg::mig_stat_t stat_q = 4'b0010;     // only rd_empty set.
    logic [31:0]            rd_data_q = 32'h0;

    assign stat_o    = stat_q;
    assign rd_data_o = rd_data_q;

    always @(posedge clk) begin
        if (rst) begin
            wr_fifo.delete();
            rd_pend.delete();
            rd_fifo.delete();
            rd_wait = 0;
            stat_q    <= 4'b0010;
            rd_data_q <= 32'h0;
        end else begin
            // *****************************************************************
            // port protocol
            // *****************************************************************
            if (cmd_i.en && stat_q.cmd_full) begin
                errors++;
                $display("model at %0t: command pushed while cmd_full", $time);
            end
            if (wr_i.en && stat_q.wr_full) begin
                errors++;
                $display("model at %0t: write data pushed while wr_full", $time);
            end
            if (wr_i.en && (wr_i.mask != 4'b0000)) begin
                errors++;
                $display("Fail at %0t: wr mask got %b expected 0000", $time, wr_i.mask);
            end

            if (wr_i.en) wr_fifo.push_back(wr_i.data);

            if (rd_en_i) begin
                if (rd_fifo.size() == 0) begin
                    errors++;
                    $display("model at %0t: read fifo popped while empty", $time);
                end else begin
                    rd_fifo.delete(0);
                end
            end

            // read latency, then one word per cycle with random gaps.
            if (rd_wait > 0) begin
                rd_wait--;
            end else if (rd_pend.size() > 0) begin
                if (!(bp_en_i && (($random(seed) & 1) == 1))) begin
                    rd_fifo.push_back(rd_pend.pop_front());
                end
            end

            if (cmd_i.en) begin
                waddr = cmd_i.byte_addr[9:2];
                if ((cmd_i.instr == ddr_dma_pkg::CMD_WR)
                    && (wr_fifo.size() != int'(cmd_i.bl) + 1)) begin
                    errors++;
                    $display("model at %0t: write command for %0d words, %0d queued",
                             $time, int'(cmd_i.bl) + 1, wr_fifo.size());
                end
                for (int k = 0; k <= int'(cmd_i.bl); k++) begin
                    if (cmd_i.instr == ddr_dma_pkg::CMD_RD) begin
                        rd_pend.push_back(dram[waddr]);
                    end else if (wr_fifo.size() > 0) begin
                        dram[waddr] = wr_fifo.pop_front();
                    end
                    waddr = waddr + 8'd1;           // wraps in 256 words.
                end
                rd_wait = bp_en_i ? 2 + ($random(seed) & 7) : 1;
            end

            stat_q.cmd_full    <= bp_en_i && (($random(seed) & 3) == 0);
            stat_q.wr_full     <= (wr_fifo.size() >= 64)
                                  || (bp_en_i && (($random(seed) & 3) == 0));
            stat_q.rd_empty    <= (rd_fifo.size() == 0);
            stat_q.rd_count_nz <= (rd_fifo.size() != 0);
            rd_data_q          <= (rd_fifo.size() != 0) ? rd_fifo[0] : 32'h0;
        end
    end

endmodule

// File: tests/tb_ddr_dma.sv
`timescale 1ns/1ns

module tb_ddr_dma;

    localparam int MAX_CYCLES = 20000;     // about five times the full sequence.

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic        we;
    logic [31:0] rdata;
    logic        bp_en;

    ddr_dma_pkg::mig_cmd_t  mig_cmd;
    ddr_dma_pkg::mig_wr_t   mig_wr;
    ddr_dma_pkg::mig_stat_t mig_stat;
    logic                   mig_rd_en;
    logic [31:0]            mig_rd_data;

    logic [31:0] sh_spad [1024];
    logic [31:0] sh_dram [256];

    // bus read in flight, checked one cycle later.
    logic        rd_req;
    logic [31:0] rd_exp;
    logic        cmp_vld;
    logic [31:0] cmp_exp;
    logic [15:0] cmp_addr;

    int seed = 79777;
    int cycles = 0;
    int cmp_errs = 0;
    int cmp_checks = 0;
    int errors;
    int checks;
    int tests;
    int test_errs;

    ddr_dma_top #(
        .SPAD_AW (10)
    ) ddr_dma_top_i (
        .clk           (clk),
        .rst           (rst),
        .addr_i        (addr),
        .data_i        (wdata),
        .we_i          (we),
        .data_o        (rdata),
        .mig_cmd_o     (mig_cmd),
        .mig_wr_o      (mig_wr),
        .mig_rd_en_o   (mig_rd_en),
        .mig_rd_data_i (mig_rd_data),
        .mig_stat_i    (mig_stat)
    );

    mig_port_model model_i (
        .clk       (clk),
        .rst       (rst),
        .bp_en_i   (bp_en),
        .cmd_i     (mig_cmd),
        .wr_i      (mig_wr),
        .rd_en_i   (mig_rd_en),
        .rd_data_o (mig_rd_data),
        .stat_o    (mig_stat)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // *************************************************************************
    // reference and compare
    // *************************************************************************

    // one dma as the register rules define it, model dram wraps at 256 words.
    function automatic void ref_copy(input logic dir, input logic [31:0] dram_byte,
                                     input logic [31:0] spad_start, input logic [31:0] burst);
        logic [7:0] da;
        logic [9:0] sa;
        da = dram_byte[9:2];
        sa = spad_start[9:0];
        for (int k = 0; k <= int'(burst[5:0]); k++) begin
            if (dir) sh_dram[da] = sh_spad[sa];
            else sh_spad[sa] = sh_dram[da];
            da = da + 8'd1;
            sa = sa + 10'd1;
        end
    endfunction

    function automatic int total_errors();
        return errors + cmp_errs + model_i.errors;
    endfunction

    always @(posedge clk) begin
        cmp_vld  <= rd_req;
        cmp_exp  <= rd_exp;
        cmp_addr <= addr;
    end

    always @(negedge clk) begin
        if (cmp_vld) begin
            cmp_checks++;
            if (rdata !== cmp_exp) begin
                cmp_errs++;
                $display("Fail at %0t: data_o at %h got %h expected %h",
                         $time, cmp_addr, rdata, cmp_exp);
            end
        end
    end

    // *************************************************************************
    // bus tasks
    // *************************************************************************

    task automatic bus_drive(input logic [15:0] a, input logic [31:0] d, input logic w,
                             input logic r, input logic [31:0] e);
        @(posedge clk);
        #2;
        addr   = a;
        wdata  = d;
        we     = w;
        rd_req = r;
        rd_exp = e;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
        bus_drive(a, d, 1'b1, 1'b0, 32'h0);
    endtask

    task automatic bus_read(input logic [15:0] a, input logic [31:0] e);
        bus_drive(a, 32'h0, 1'b0, 1'b1, e);
    endtask

    task automatic bus_idle();
        bus_drive(16'h0, 32'h0, 1'b0, 1'b0, 32'h0);
    endtask

    // polls the complete flag.
    task automatic wait_done();
        logic done;
        done = 1'b0;
        while (!done) begin
            bus_drive(ddr_dma_pkg::REG_CTRL, 32'h0, 1'b0, 1'b0, 32'h0);
            @(posedge clk);
            @(negedge clk);
            done = rdata[0];
        end
    endtask

    task automatic check_dram();
        for (int i = 0; i < 256; i++) begin
            checks++;
            if (model_i.dram[i] !== sh_dram[i]) begin
                errors++;
                $display("Fail at %0t: dram[%0d] got %h expected %h",
                         $time, i, model_i.dram[i], sh_dram[i]);
            end
        end
    endtask

    task automatic run_dma(input logic dir, input logic [31:0] dram_byte,
                           input logic [31:0] spad_start, input logic [31:0] burst,
                           input logic poke);
        logic [9:0] sa;
        bus_write(ddr_dma_pkg::REG_DRAM_ADDR, dram_byte);
        bus_write(ddr_dma_pkg::REG_SPAD_ADDR, spad_start);
        bus_write(ddr_dma_pkg::REG_BURST, burst);
        bus_write(ddr_dma_pkg::REG_CTRL, {31'b0, dir});
        if (poke) begin
            bus_idle();                                   // engine has left idle.
            bus_write(ddr_dma_pkg::REG_CTRL, {31'b0, ~dir});   // engine busy.
        end
        wait_done();
        ref_copy(dir, dram_byte, spad_start, burst);
        if (dir) begin
            check_dram();
        end else begin
            sa = spad_start[9:0];
            for (int k = 0; k <= int'(burst[5:0]); k++) begin
                bus_read({6'b000100, sa}, sh_spad[sa]);
                sa = sa + 10'd1;
            end
        end
        bus_read(ddr_dma_pkg::REG_CTRL, 32'h1);
    endtask

    task automatic end_test(input string name);
        int now;
        bus_idle();
        @(negedge clk);
        #1;
        now = total_errors();
        tests++;
        if (now == test_errs) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, now - test_errs);
        end
        test_errs = now;
    endtask

    // *************************************************************************
    // test sequence
    // *************************************************************************

    initial begin
        logic [31:0] r;
        logic [9:0]  a;
        rst       = 1'b1;
        addr      = 16'h0;
        wdata     = 32'h0;
        we        = 1'b0;
        rd_req    = 1'b0;
        rd_exp    = 32'h0;
        bp_en     = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        test_errs = 0;
        for (int i = 0; i < 256; i++) begin
            model_i.dram[i] = {8'hd5, i[7:0], ~i[7:0], i[7:0]};
            sh_dram[i]      = {8'hd5, i[7:0], ~i[7:0], i[7:0]};
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (10) begin
            @(negedge clk);
            checks++;
            if (mig_cmd.en || mig_wr.en || mig_rd_en) begin
                errors++;
                $display("controller strobe active at %0t before any control write", $time);
            end
        end
        end_test("quiet after reset");

        for (int i = 0; i < 1024; i++) begin
            r = $random(seed);
            a = i[9:0];
            bus_write({6'b000100, a}, r);
            sh_spad[a] = r;
        end
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            a = r[9:0];
            bus_read({6'b000100, a}, sh_spad[a]);
        end
        end_test("scratchpad access");

        bus_write(ddr_dma_pkg::REG_DRAM_ADDR, 32'hf123_4567);
        bus_write(ddr_dma_pkg::REG_SPAD_ADDR, 32'h0000_fabc);
        bus_write(ddr_dma_pkg::REG_BURST, 32'h0000_00e7);
        bus_read(ddr_dma_pkg::REG_DRAM_ADDR, 32'hf123_4567 & 32'h07ff_fffc);
        bus_read(ddr_dma_pkg::REG_SPAD_ADDR, 32'h0000_fabc & 32'h0000_03ff);
        bus_read(ddr_dma_pkg::REG_BURST, 32'h0000_00e7 & 32'h0000_003f);
        bus_read(ddr_dma_pkg::REG_CTRL, 32'h1);
        end_test("register readback");

        run_dma(1'b1, 32'h0000_0140, 32'h0000_0100, 32'd15, 1'b0);
        end_test("dma write");

        run_dma(1'b0, 32'h0000_0140, 32'h0000_0300, 32'd15, 1'b0);
        end_test("dma read");

        bp_en = 1'b1;
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            run_dma(~i[0], {22'b0, r[9:2], 2'b00}, {22'b0, r[19:10]}, {26'b0, r[25:20]}, 1'b1);
        end
        bp_en = 1'b0;
        end_test("back-pressure transfers");

        $display("tests %0d, checks %0d, errors %0d", tests, checks + cmp_checks, total_errors());
        if (total_errors() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: flist.f
hw/ddr_dma_pkg.sv
hw/spad_ram.sv
hw/dma_regs.sv
hw/dma_engine.sv
hw/ddr_dma_top.sv
tests/mig_port_model.sv
tests/tb_ddr_dma.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_ddr_dma -f flist.f -o sim_ddr_dma

run: compile
	./obj_dir/sim_ddr_dma | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
